// ==== vlog.f ====
+incdir+include
hdl/sta_pkg.sv
hdl/sta_graph_capture.sv
hdl/sta_topo_order.sv
hdl/sta_arrival.sv
hdl/sta_path_trace.sv
hdl/sta_top.sv
sim/tb_sta.sv

// ==== Makefile ====
# Verilator build and run for the static timing analyser testbench

VERILATOR ?= verilator
TOP       ?= tb_sta
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/sta_model.svh ====
// ----------------------------------------------------------------------
// Reference model for the static timing analyser testbench
// Random DAG generator, arrival times over the rank order, worst
// delay and the critical path with the lowest-index tie rule
// ----------------------------------------------------------------------
`ifndef STA_MODEL_SVH
`define STA_MODEL_SVH

int rank_order [sta_pkg::NUM_NODES];
int model_delay [sta_pkg::NUM_NODES];
int model_arrival [sta_pkg::NUM_NODES];
bit model_adj [sta_pkg::NUM_NODES][sta_pkg::NUM_NODES];
int edge_src [$];
int edge_dst [$];
int model_path [$];
int model_worst;

task automatic clear_graph();
	edge_src.delete();
	edge_dst.delete();
	foreach (model_adj[i, j])
		model_adj[i][j] = 1'b0;
	// Identity rank order, node 0 first and node 1 last
	rank_order[0] = sta_pkg::SOURCE_NODE;
	for (int r = 1; r < sta_pkg::NUM_NODES - 1; r++)
		rank_order[r] = r + 1;
	rank_order[sta_pkg::NUM_NODES - 1] = sta_pkg::SINK_NODE;
endtask

task automatic add_edge(input int src, input int dst);
	edge_src.push_back(src);
	edge_dst.push_back(dst);
	model_adj[src][dst] = 1'b1;
endtask

// Edges only ever go from a lower rank to a higher one
task automatic build_random_graph(input int extra_edges);
	int j;
	int tmp;
	int a;
	int b;
	clear_graph();
	for (int r = sta_pkg::NUM_NODES - 2; r >= 2; r--) begin
		j = 1 + int'($urandom % r);
		tmp = rank_order[r];
		rank_order[r] = rank_order[j];
		rank_order[j] = tmp;
	end
	for (int r = 1; r < sta_pkg::NUM_NODES; r++)
		add_edge(rank_order[int'($urandom % r)], rank_order[r]);
	for (int k = 0; k < extra_edges; k++) begin
		a = int'($urandom % sta_pkg::NUM_NODES);
		b = int'($urandom % sta_pkg::NUM_NODES);
		if (a > b) begin
			tmp = a;
			a = b;
			b = tmp;
		end
		if (a != b)
			add_edge(rank_order[a], rank_order[b]);
	end
	foreach (model_delay[i])
		model_delay[i] = int'($urandom % 16);
endtask

task automatic compute_arrivals();
	int n;
	int cand;
	foreach (model_arrival[i])
		model_arrival[i] = 0;
	for (int r = 0; r < sta_pkg::NUM_NODES; r++) begin
		n = rank_order[r];
		cand = model_arrival[n] + model_delay[n];
		foreach (edge_src[e])
			if (edge_src[e] == n && cand > model_arrival[edge_dst[e]])
				model_arrival[edge_dst[e]] = cand;
	end
	model_worst = model_arrival[sta_pkg::SINK_NODE] + model_delay[sta_pkg::SINK_NODE];
endtask

// Walk back from the sink, lowest matching predecessor first
task automatic trace_model_path();
	int cur;
	int best;
	int steps;
	model_path.delete();
	cur = sta_pkg::SINK_NODE;
	model_path.push_front(cur);
	steps = 0;
	while (cur != sta_pkg::SOURCE_NODE && steps < sta_pkg::NUM_NODES) begin
		best = sta_pkg::SOURCE_NODE;
		for (int i = sta_pkg::NUM_NODES - 1; i >= 0; i--)
			if (model_adj[i][cur] && model_arrival[i] + model_delay[i] == model_arrival[cur])
				best = i;
		cur = best;
		model_path.push_front(cur);
		steps++;
	end
endtask

`endif

// ==== sim/tb_sta.sv ====
// ----------------------------------------------------------------------
// Static timing analyser testbench
// Drives a directed chain and random DAG bursts into the DUT and
// checks worst delay and critical path against the reference model
// ----------------------------------------------------------------------
module tb_sta;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int NUM_JOBS       = 60;
	localparam int CYCLES_PER_JOB = 200;
	localparam int MAX_CYCLES     = NUM_JOBS * CYCLES_PER_JOB;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              in_valid;
	sta_pkg::delay_t   delay;
	sta_pkg::node_t    source;
	sta_pkg::node_t    destination;
	logic              out_valid;
	sta_pkg::arrival_t worst_delay;
	sta_pkg::node_t    path;

	int cycle_count = 0;
	int dut_worst;
	int dut_path [$];
	int extra;

	`include "sta_model.svh"

	sta_top u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.delay       (delay),
		.source      (source),
		.destination (destination),
		.out_valid   (out_valid),
		.worst_delay (worst_delay),
		.path        (path)
	);

	always #10 clk = ~clk;

	// Run length guard
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the DUT did not finish all jobs within %0d cycles", MAX_CYCLES);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_idle();
		check_value("out_valid", 0, int'(out_valid));
		check_value("path", 0, int'(path));
		check_value("worst_delay", 0, int'(worst_delay));
	endtask

	// Chain 0 -> 2 -> 1 with every other node hanging off node 0
	task automatic load_chain_graph();
		clear_graph();
		add_edge(0, 2);
		add_edge(2, 1);
		for (int k = 3; k < sta_pkg::NUM_NODES; k++)
			add_edge(0, k);
		foreach (model_delay[i])
			model_delay[i] = 0;
		model_delay[0] = 3;
		model_delay[2] = 4;
		model_delay[1] = 5;
	endtask

	// ------------------------------------------------------------------
	// One job with its burst, the wait and the output run check
	// ------------------------------------------------------------------
	task automatic run_job();
		int n;
		int burst_len;
		int e;
		int idx;
		compute_arrivals();
		trace_model_path();
		n = edge_src.size();
		burst_len = (n > sta_pkg::NUM_NODES) ? n : sta_pkg::NUM_NODES;
		for (int c = 0; c < burst_len; c++) begin
			check_idle();
			// Extra cycles repeat the last edge
			e = (c < n) ? c : n - 1;
			in_valid    = 1'b1;
			delay       = (c < sta_pkg::NUM_NODES) ? sta_pkg::delay_t'(model_delay[c]) : '0;
			source      = sta_pkg::node_t'(edge_src[e]);
			destination = sta_pkg::node_t'(edge_dst[e]);
			@(negedge clk);
		end
		in_valid    = 1'b0;
		delay       = '0;
		source      = '0;
		destination = '0;
		while (!out_valid) begin
			check_idle();
			@(negedge clk);
		end
		dut_path.delete();
		dut_worst = int'(worst_delay);
		idx = 0;
		while (out_valid) begin
			check_value("worst_delay", (idx == 0) ? model_worst : 0, int'(worst_delay));
			if (idx < model_path.size())
				check_value("path", model_path[idx], int'(path));
			dut_path.push_back(int'(path));
			idx++;
			@(negedge clk);
		end
		check_value("path length", model_path.size(), idx);
		check_value("path first node", sta_pkg::SOURCE_NODE, dut_path[0]);
		check_value("path last node", sta_pkg::SINK_NODE, dut_path[dut_path.size() - 1]);
	endtask

	initial begin
		void'($urandom(34));
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		delay       = '0;
		source      = '0;
		destination = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Quiet outputs before any burst
		repeat (4) begin
			@(negedge clk);
			check_idle();
		end

		load_chain_graph();
		run_job();
		check_value("chain worst_delay", 12, dut_worst);
		check_value("chain path length", 3, dut_path.size());
		check_value("chain path[0]", 0, dut_path[0]);
		check_value("chain path[1]", 2, dut_path[1]);
		check_value("chain path[2]", 1, dut_path[2]);

		// Dense, sparse and mixed graphs back to back
		for (int job = 0; job < NUM_JOBS; job++) begin
			if (job % 3 == 0)
				extra = 40;
			else if (job % 3 == 1)
				extra = 0;
			else
				extra = int'($urandom % 41);
			build_random_graph(extra);
			run_job();
		end

		// No second output run after the last job
		repeat (2 * sta_pkg::NUM_NODES) begin
			@(negedge clk);
			check_idle();
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== hdl/sta_top.sv ====
// ----------------------------------------------------------------------
// Static timing analyser top level
// Capture, topological order, arrival and path trace stages
// ----------------------------------------------------------------------
module sta_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  sta_pkg::delay_t   delay,
	input  sta_pkg::node_t    source,
	input  sta_pkg::node_t    destination,
	output logic              out_valid,
	output sta_pkg::arrival_t worst_delay,
	output sta_pkg::node_t    path
);

	sta_pkg::node_mask_t edge_row [sta_pkg::NUM_NODES];
	sta_pkg::delay_t     node_delay [sta_pkg::NUM_NODES];
	sta_pkg::arrival_t   arrival [sta_pkg::NUM_NODES];
	logic                graph_ready;
	logic                pick_valid;
	sta_pkg::node_t      pick_node;
	logic                order_done;
	logic                arrival_done;

	sta_graph_capture u_capture (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.delay       (delay),
		.source      (source),
		.destination (destination),
		.edge_row    (edge_row),
		.node_delay  (node_delay),
		.graph_ready (graph_ready)
	);

	sta_topo_order u_order (
		.clk         (clk),
		.rst_n       (rst_n),
		.graph_ready (graph_ready),
		.edge_row    (edge_row),
		.pick_valid  (pick_valid),
		.pick_node   (pick_node),
		.order_done  (order_done)
	);

	// Runs alongside the order stage, one pick behind
	sta_arrival u_arrival (
		.clk          (clk),
		.rst_n        (rst_n),
		.graph_ready  (graph_ready),
		.edge_row     (edge_row),
		.node_delay   (node_delay),
		.pick_valid   (pick_valid),
		.pick_node    (pick_node),
		.order_done   (order_done),
		.arrival      (arrival),
		.arrival_done (arrival_done)
	);

	sta_path_trace u_trace (
		.clk          (clk),
		.rst_n        (rst_n),
		.arrival_done (arrival_done),
		.edge_row     (edge_row),
		.node_delay   (node_delay),
		.arrival      (arrival),
		.out_valid    (out_valid),
		.worst_delay  (worst_delay),
		.path         (path)
	);

endmodule

// ==== hdl/sta_path_trace.sv ====
// ----------------------------------------------------------------------
// Critical path trace stage
// Walks back from the capture node along the edges that set each
// arrival, then streams the path from launch to capture with the
// worst delay on the first output cycle
// ----------------------------------------------------------------------
module sta_path_trace (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                arrival_done,
	input  sta_pkg::node_mask_t edge_row [sta_pkg::NUM_NODES],
	input  sta_pkg::delay_t     node_delay [sta_pkg::NUM_NODES],
	input  sta_pkg::arrival_t   arrival [sta_pkg::NUM_NODES],
	output logic                out_valid,
	output sta_pkg::arrival_t   worst_delay,
	output sta_pkg::node_t      path
);

	sta_pkg::node_t    path_buf [sta_pkg::NUM_NODES];
	sta_pkg::node_t    cur_node;
	sta_pkg::node_t    cur_eff;
	sta_pkg::node_t    pred;
	logic [3:0]        wr_idx;
	logic [3:0]        wr_eff;
	logic [3:0]        rd_idx;
	logic              walking;
	logic              replay;
	logic              step;
	logic              at_source;
	sta_pkg::arrival_t sink_total;

	// Walk starts on the arrival_done cycle itself
	assign step      = arrival_done || walking;
	assign cur_eff   = arrival_done ? sta_pkg::node_t'(sta_pkg::SINK_NODE) : cur_node;
	assign wr_eff    = arrival_done ? 4'd0 : wr_idx;
	assign at_source = cur_eff == sta_pkg::node_t'(sta_pkg::SOURCE_NODE);

	assign sink_total = arrival[sta_pkg::SINK_NODE]
		+ sta_pkg::arrival_t'(node_delay[sta_pkg::SINK_NODE]);

	// ------------------------------------------------------------------
	// Predecessor that set the current arrival, lowest index first
	// ------------------------------------------------------------------
	always_comb begin
		sta_pkg::arrival_t cand;
		pred = '0;
		for (int i = sta_pkg::NUM_NODES - 1; i >= 0; i--) begin
			cand = arrival[i] + sta_pkg::arrival_t'(node_delay[i]);
			if (edge_row[i][cur_eff] && cand == arrival[cur_eff])
				pred = sta_pkg::node_t'(i);
		end
	end

	// Nodes stored sink first, replayed in reverse
	always_ff @(posedge clk) begin
		if (step)
			path_buf[wr_eff] <= cur_eff;
	end

	// ------------------------------------------------------------------
	// Walk and replay control
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			walking     <= 1'b0;
			replay      <= 1'b0;
			cur_node    <= '0;
			wr_idx      <= '0;
			rd_idx      <= '0;
			out_valid   <= 1'b0;
			path        <= '0;
			worst_delay <= '0;
		end else begin
			out_valid   <= 1'b0;
			path        <= '0;
			worst_delay <= '0;
			if (step) begin
				if (at_source) begin
					// Source goes out directly, the rest from the buffer
					walking     <= 1'b0;
					replay      <= 1'b1;
					rd_idx      <= wr_eff - 4'd1;
					out_valid   <= 1'b1;
					path        <= sta_pkg::node_t'(sta_pkg::SOURCE_NODE);
					worst_delay <= sink_total;
				end else begin
					walking  <= 1'b1;
					cur_node <= pred;
					wr_idx   <= wr_eff + 4'd1;
				end
			end else if (replay) begin
				out_valid <= 1'b1;
				path      <= path_buf[rd_idx];
				rd_idx    <= rd_idx - 4'd1;
				// Entry 0 holds the sink
				if (rd_idx == 4'd0)
					replay <= 1'b0;
			end
		end
	end

endmodule

// ==== hdl/sta_arrival.sv ====
// ----------------------------------------------------------------------
// Arrival time stage
// Relaxes the latest arrival of every successor as nodes come out
// of the topological order
// ----------------------------------------------------------------------
module sta_arrival (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                graph_ready,
	input  sta_pkg::node_mask_t edge_row [sta_pkg::NUM_NODES],
	input  sta_pkg::delay_t     node_delay [sta_pkg::NUM_NODES],
	input  logic                pick_valid,
	input  sta_pkg::node_t      pick_node,
	input  logic                order_done,
	output sta_pkg::arrival_t   arrival [sta_pkg::NUM_NODES],
	output logic                arrival_done
);

	sta_pkg::arrival_t   launch;
	sta_pkg::node_mask_t succ;

	// The picked node is final here, all its predecessors came earlier
	assign launch = arrival[pick_node] + sta_pkg::arrival_t'(node_delay[pick_node]);
	assign succ   = edge_row[pick_node];

	// ------------------------------------------------------------------
	// Arrival table
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		for (int j = 0; j < sta_pkg::NUM_NODES; j++) begin
			if (graph_ready) begin
				arrival[j] <= '0;
			end else if (pick_valid && succ[j]) begin
				// Keep the latest of all incoming edges
				if (launch > arrival[j])
					arrival[j] <= launch;
			end
		end
	end

	// Last relaxation lands with this pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			arrival_done <= 1'b0;
		else
			arrival_done <= order_done;
	end

endmodule

// ==== hdl/sta_topo_order.sv ====
// ----------------------------------------------------------------------
// Topological order stage
// Emits every node once, one per cycle, each only after all of its
// predecessors; ties go to the lowest node index
// ----------------------------------------------------------------------
module sta_topo_order (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                graph_ready,
	input  sta_pkg::node_mask_t edge_row [sta_pkg::NUM_NODES],
	output logic                pick_valid,
	output sta_pkg::node_t      pick_node,
	output logic                order_done
);

	sta_pkg::node_mask_t done_mask;
	sta_pkg::node_mask_t done_eff;
	sta_pkg::node_mask_t ready;
	logic [3:0]          pick_cnt;
	logic [3:0]          cnt_eff;
	logic                running;
	logic                active;
	logic                found;
	logic                last_pick;
	sta_pkg::node_t      sel;

	// The graph_ready cycle already picks, with an empty done set
	assign active    = graph_ready || running;
	assign done_eff  = graph_ready ? '0 : done_mask;
	assign cnt_eff   = graph_ready ? 4'd0 : pick_cnt;
	assign last_pick = cnt_eff == 4'(sta_pkg::NUM_NODES - 1);

	// ------------------------------------------------------------------
	// Readiness from the matrix columns
	// ------------------------------------------------------------------
	always_comb begin
		for (int j = 0; j < sta_pkg::NUM_NODES; j++) begin
			ready[j] = !done_eff[j];
			for (int i = 0; i < sta_pkg::NUM_NODES; i++) begin
				// Any predecessor not yet ordered blocks node j
				if (edge_row[i][j] && !done_eff[i])
					ready[j] = 1'b0;
			end
		end
	end

	// Lowest ready index wins
	always_comb begin
		found = 1'b0;
		sel   = '0;
		for (int j = sta_pkg::NUM_NODES - 1; j >= 0; j--) begin
			if (ready[j]) begin
				found = 1'b1;
				sel   = sta_pkg::node_t'(j);
			end
		end
	end

	// ------------------------------------------------------------------
	// Pick register
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running    <= 1'b0;
			pick_cnt   <= '0;
			done_mask  <= '0;
			pick_valid <= 1'b0;
			pick_node  <= '0;
			order_done <= 1'b0;
		end else begin
			pick_valid <= active && found;
			order_done <= active && found && last_pick;
			running    <= active && !last_pick;
			if (active && found) begin
				pick_node <= sel;
				done_mask <= done_eff | (sta_pkg::node_mask_t'(1) << sel);
				pick_cnt  <= cnt_eff + 4'd1;
			end
		end
	end

endmodule

// ==== hdl/sta_graph_capture.sv ====
// ----------------------------------------------------------------------
// Graph capture stage
// Builds the edge matrix and the node delay table from one input
// burst, then pulses graph_ready once the burst has ended
// ----------------------------------------------------------------------
module sta_graph_capture (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  sta_pkg::delay_t     delay,
	input  sta_pkg::node_t      source,
	input  sta_pkg::node_t      destination,
	output sta_pkg::node_mask_t edge_row [sta_pkg::NUM_NODES],
	output sta_pkg::delay_t     node_delay [sta_pkg::NUM_NODES],
	output logic                graph_ready
);

	logic                in_valid_q;
	logic [4:0]          burst_cnt;
	logic [4:0]          delay_idx;
	logic                burst_start;
	sta_pkg::node_mask_t dest_bit;

	assign burst_start = in_valid && !in_valid_q;

	// Index of the node whose delay arrives this cycle
	assign delay_idx = burst_start ? 5'd0 : burst_cnt;

	assign dest_bit = sta_pkg::node_mask_t'(1) << destination;

	// ------------------------------------------------------------------
	// Burst tracking
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_valid_q  <= 1'b0;
			burst_cnt   <= '0;
			graph_ready <= 1'b0;
		end else begin
			in_valid_q  <= in_valid;
			graph_ready <= in_valid_q && !in_valid;
			// Saturates at 16, restarted by the next burst
			if (in_valid && delay_idx != 5'(sta_pkg::NUM_NODES))
				burst_cnt <= delay_idx + 5'd1;
		end
	end

	// ------------------------------------------------------------------
	// Edge matrix and delay table
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		for (int i = 0; i < sta_pkg::NUM_NODES; i++) begin
			if (burst_start) begin
				// First edge lands while the old graph is wiped
				edge_row[i]   <= (sta_pkg::node_t'(i) == source) ? dest_bit : '0;
				node_delay[i] <= (i == 0) ? delay : '0;
			end else if (in_valid) begin
				if (sta_pkg::node_t'(i) == source)
					edge_row[i] <= edge_row[i] | dest_bit;
				if (delay_idx == 5'(i))
					node_delay[i] <= delay;
			end
		end
	end

endmodule

// ==== hdl/sta_pkg.sv ====
// ----------------------------------------------------------------------
// Static timing analyser shared definitions
// Graph size, launch and capture nodes, and the value widths used
// by every stage of the pipeline
// ----------------------------------------------------------------------
package sta_pkg;

	// ------------------------------------------------------------------
	// Graph constants
	// ------------------------------------------------------------------
	localparam int NUM_NODES = 16;

	// Launch point of every timing path
	localparam int SOURCE_NODE = 0;

	// Capture point, has no successors
	localparam int SINK_NODE = 1;

	// ------------------------------------------------------------------
	// Value types
	// ------------------------------------------------------------------

	// Node index
	typedef logic [3:0] node_t;

	// One bit per node, edge matrix row or node set
	typedef logic [NUM_NODES-1:0] node_mask_t;

	// Delay of a single node
	typedef logic [3:0] delay_t;

	// Arrival time, wide enough for 15 hops of delay 15
	typedef logic [7:0] arrival_t;

endpackage
